/* plic_subsys.f */
+incdir+tests
verilog/plic_pkg.sv
verilog/plic_gateway.sv
verilog/plic_arbiter.sv
verilog/plic_core.sv
verilog/plic_top.sv
tests/plic_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary -j 0 -Wno-fatal
TOP      := plic_tb
FILELIST := plic_subsys.f
OBJ_DIR  := obj_dir
PASS_MSG := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/plic_tb_model.svh */
`ifndef PLIC_TB_MODEL_SVH
`define PLIC_TB_MODEL_SVH

// mirror of the register file and the gateways
prio_t           m_prio [1:NSRC];
logic [NSRC:1]   m_enable;
prio_t           m_threshold;
logic [NSRC:1]   m_pending;
logic [NSRC:1]   m_in_service;
logic [NSRC:1]   m_level;

function automatic axi_data_t model_read(input axi_addr_t addr);
    axi_addr_t word;
    int        idx;
    axi_data_t val;
    word = {addr[15:2], 2'b00};
    idx  = int'(word[7:2]);
    val  = '0;
    if (word < 16'h0100) begin
        if (idx >= 1 && idx <= NSRC) begin
            val = axi_data_t'(m_prio[idx]);
        end
    end else if (word == PENDING_OFFS) begin
        for (int n = 1; n <= NSRC; n++) begin
            val[n] = m_pending[n];
        end
    end else if (word == ENABLE_OFFS) begin
        for (int n = 1; n <= NSRC; n++) begin
            val[n] = m_enable[n];
        end
    end else if (word == THRESHOLD_OFFS) begin
        val = axi_data_t'(m_threshold);
    end
    return val;
endfunction

function automatic void model_write(input axi_addr_t addr, input axi_data_t data,
                                    input axi_strb_t strb);
    axi_addr_t word;
    int        idx;
    word = {addr[15:2], 2'b00};
    idx  = int'(word[7:2]);
    if (word < 16'h0100) begin
        if (idx >= 1 && idx <= NSRC && strb[0]) begin
            m_prio[idx] = data[2:0];
        end
    end else if (word == ENABLE_OFFS) begin
        for (int n = 1; n <= NSRC; n++) begin
            if (strb[n / 8]) begin
                m_enable[n] = data[n];
            end
        end
    end else if (word == THRESHOLD_OFFS) begin
        if (strb[0]) begin
            m_threshold = data[2:0];
        end
    end else if (word == CLAIM_OFFS) begin
        // completing a source that is not in service is a no-op
        if (data >= 1 && data <= NSRC) begin
            m_in_service[int'(data)] = 1'b0;
        end
    end
endfunction

// best enabled pending source above the threshold, lowest id on ties
function automatic src_id_t model_claim();
    src_id_t id;
    prio_t   top;
    id  = '0;
    top = '0;
    for (int n = 1; n <= NSRC; n++) begin
        if (m_pending[n] && m_enable[n] && m_prio[n] > top) begin
            top = m_prio[n];
            id  = src_id_t'(n);
        end
    end
    return (top > m_threshold) ? id : src_id_t'(0);
endfunction

function automatic void model_take(input src_id_t id);
    if (id != 0) begin
        m_pending[int'(id)]    = 1'b0;
        m_in_service[int'(id)] = 1'b1;
    end
endfunction

// levels seen high while not in service latch pending
function automatic void model_settle();
    m_pending = m_pending | (m_level & ~m_in_service);
endfunction

`endif

/* tests/plic_tb.sv */
`timescale 1ns/1ps

module plic_tb;

    import plic_pkg::*;

    localparam int NSRC           = 8;
    localparam int CLK_PERIOD     = 20;
    localparam int N_REG          = 300;
    localparam int N_ROUNDS       = 120;
    localparam int N_TXNS         = 2 * N_REG + 2 * N_ROUNDS + 8;
    localparam int TIMEOUT_CYCLES = 200 * N_TXNS;

    logic             S_AXI_ACLK;
    logic             S_AXI_ARESETN;
    axi_addr_t        awaddr;
    logic             awvalid;
    logic             awready;
    axi_data_t        wdata;
    axi_strb_t        wstrb;
    logic             wvalid;
    logic             wready;
    logic [1:0]       bresp;
    logic             bvalid;
    logic             bready;
    axi_addr_t        araddr;
    logic             arvalid;
    logic             arready;
    axi_data_t        rdata;
    logic [1:0]       rresp;
    logic             rvalid;
    logic             rready;
    logic [NSRC-1:0]  irq_src;
    logic             irq_valid;

    `include "plic_tb_model.svh"

    plic_top #(
        .NUM_SOURCES(NSRC)
    ) dut_i (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .S_AXI_AWADDR (awaddr),
        .S_AXI_AWPROT (3'b000),
        .S_AXI_AWVALID(awvalid),
        .S_AXI_AWREADY(awready),
        .S_AXI_WDATA  (wdata),
        .S_AXI_WSTRB  (wstrb),
        .S_AXI_WVALID (wvalid),
        .S_AXI_WREADY (wready),
        .S_AXI_BRESP  (bresp),
        .S_AXI_BVALID (bvalid),
        .S_AXI_BREADY (bready),
        .S_AXI_ARADDR (araddr),
        .S_AXI_ARPROT (3'b000),
        .S_AXI_ARVALID(arvalid),
        .S_AXI_ARREADY(arready),
        .S_AXI_RDATA  (rdata),
        .S_AXI_RRESP  (rresp),
        .S_AXI_RVALID (rvalid),
        .S_AXI_RREADY (rready),
        .irq_sources  (irq_src),
        .irq_valid    (irq_valid)
    );

    initial begin
        S_AXI_ACLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge S_AXI_ACLK);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_id(input string name, input src_id_t exp, input src_id_t act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             input axi_strb_t strb);
        int   aw_wait;
        int   w_wait;
        int   stall;
        logic aw_done;
        logic w_done;
        aw_wait = $urandom_range(0, 2);
        w_wait  = $urandom_range(0, 2);
        stall   = $urandom_range(0, 5);
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge S_AXI_ACLK);
        awaddr <= addr;
        wdata  <= data;
        wstrb  <= strb;
        // random AW/W order, each handshake seen at the negedge before its edge
        while (!(aw_done && w_done)) begin
            if (!aw_done) begin
                if (aw_wait == 0) awvalid <= 1'b1;
                else aw_wait--;
            end
            if (!w_done) begin
                if (w_wait == 0) wvalid <= 1'b1;
                else w_wait--;
            end
            @(negedge S_AXI_ACLK);
            if (awvalid && awready) aw_done = 1'b1;
            if (wvalid && wready) w_done = 1'b1;
            @(posedge S_AXI_ACLK);
            if (aw_done) awvalid <= 1'b0;
            if (w_done) wvalid <= 1'b0;
        end
        do begin
            @(negedge S_AXI_ACLK);
        end while (!bvalid);
        check_resp("S_AXI_BRESP", 2'b00, bresp);
        repeat (stall) begin
            @(negedge S_AXI_ACLK);
            check_bit("S_AXI_BVALID", 1'b1, bvalid);
            check_bit("S_AXI_AWREADY", 1'b0, awready);
            check_bit("S_AXI_WREADY", 1'b0, wready);
        end
        @(posedge S_AXI_ACLK);
        bready <= 1'b1;
        @(negedge S_AXI_ACLK);
        check_bit("S_AXI_BVALID", 1'b1, bvalid);
        @(posedge S_AXI_ACLK);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
        int   ar_wait;
        int   stall;
        logic ar_done;
        ar_wait = $urandom_range(0, 2);
        stall   = $urandom_range(0, 5);
        ar_done = 1'b0;
        @(posedge S_AXI_ACLK);
        araddr <= addr;
        while (!ar_done) begin
            if (ar_wait == 0) arvalid <= 1'b1;
            else ar_wait--;
            @(negedge S_AXI_ACLK);
            if (arvalid && arready) ar_done = 1'b1;
            @(posedge S_AXI_ACLK);
            if (ar_done) arvalid <= 1'b0;
        end
        do begin
            @(negedge S_AXI_ACLK);
        end while (!rvalid);
        data = rdata;
        check_resp("S_AXI_RRESP", 2'b00, rresp);
        // data must hold under RREADY back-pressure
        repeat (stall) begin
            @(negedge S_AXI_ACLK);
            check_bit("S_AXI_RVALID", 1'b1, rvalid);
            check_bit("S_AXI_ARREADY", 1'b0, arready);
            check_data("S_AXI_RDATA", data, rdata);
        end
        @(posedge S_AXI_ACLK);
        rready <= 1'b1;
        @(negedge S_AXI_ACLK);
        check_bit("S_AXI_RVALID", 1'b1, rvalid);
        @(posedge S_AXI_ACLK);
        rready <= 1'b0;
    endtask

    // irq_valid can lag two edges behind a change
    task automatic settle_and_check_irq();
        repeat (4) @(posedge S_AXI_ACLK);
        @(negedge S_AXI_ACLK);
        model_settle();
        check_bit("irq_valid", model_claim() != 0, irq_valid);
    endtask

    function automatic axi_addr_t random_reg_addr();
        case ($urandom_range(0, 5))
            0, 1:    return axi_addr_t'(4 * $urandom_range(0, 11));
            2:       return ENABLE_OFFS;
            3:       return THRESHOLD_OFFS;
            4:       return PENDING_OFFS;
            default: return axi_addr_t'(16'h4000 + 4 * $urandom_range(0, 1023));
        endcase
    endfunction

    task automatic random_reg_write(output axi_addr_t addr);
        axi_data_t data;
        axi_strb_t strb;
        addr = random_reg_addr();
        data = axi_data_t'($urandom);
        strb = axi_strb_t'($urandom_range(0, 15));
        axi_write(addr, data, strb);
        model_write(addr, data, strb);
    endtask

    initial begin
        axi_addr_t   addr;
        axi_data_t   rd;
        src_id_t     exp_id;
        logic [31:0] r;
        int          id;
        void'($urandom(32'h40d4));
        m_enable      = '0;
        m_threshold   = '0;
        m_pending     = '0;
        m_in_service  = '0;
        m_level       = '0;
        for (int n = 1; n <= NSRC; n++) begin
            m_prio[n] = '0;
        end
        S_AXI_ARESETN <= 1'b0;
        awaddr  <= '0;
        awvalid <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        irq_src <= '0;
        repeat (10) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;
        @(negedge S_AXI_ACLK);
        check_bit("S_AXI_AWREADY", 1'b0, awready);
        check_bit("S_AXI_WREADY", 1'b0, wready);
        check_bit("S_AXI_ARREADY", 1'b0, arready);
        check_bit("S_AXI_BVALID", 1'b0, bvalid);
        check_bit("S_AXI_RVALID", 1'b0, rvalid);
        check_bit("irq_valid", 1'b0, irq_valid);

        // register readback with random strobes
        for (int i = 0; i < N_REG; i++) begin
            random_reg_write(addr);
            settle_and_check_irq();
            axi_read(addr, rd);
            check_data("S_AXI_RDATA", model_read(addr), rd);
        end

        // source levels, claims and completes
        for (int i = 0; i < N_ROUNDS; i++) begin
            case ($urandom_range(0, 3))
                0: begin
                    r = $urandom;
                    @(posedge S_AXI_ACLK);
                    irq_src <= r[NSRC-1:0];
                    m_level = r[NSRC-1:0];
                end
                1: begin
                    exp_id = model_claim();
                    axi_read(CLAIM_OFFS, rd);
                    check_id("claim id", exp_id, src_id_t'(rd));
                    model_take(exp_id);
                end
                2: begin
                    id = $urandom_range(0, NSRC + 1);
                    // bias toward a source that is actually in service
                    if ($urandom_range(0, 1) == 1) begin
                        for (int n = NSRC; n >= 1; n--) begin
                            if (m_in_service[n]) id = n;
                        end
                    end
                    axi_write(CLAIM_OFFS, axi_data_t'(id), 4'hf);
                    model_write(CLAIM_OFFS, axi_data_t'(id), 4'hf);
                end
                default: random_reg_write(addr);
            endcase
            settle_and_check_irq();
            axi_read(PENDING_OFFS, rd);
            check_data("pending", model_read(PENDING_OFFS), rd);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* verilog/plic_top.sv */
`timescale 1ns/1ps

module plic_top #(
    parameter int NUM_SOURCES = 8
) (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    input  plic_pkg::axi_addr_t    S_AXI_AWADDR,
    input  logic [2:0]             S_AXI_AWPROT,
    input  logic                   S_AXI_AWVALID,
    output logic                   S_AXI_AWREADY,
    input  plic_pkg::axi_data_t    S_AXI_WDATA,
    input  plic_pkg::axi_strb_t    S_AXI_WSTRB,
    input  logic                   S_AXI_WVALID,
    output logic                   S_AXI_WREADY,
    output logic [1:0]             S_AXI_BRESP,
    output logic                   S_AXI_BVALID,
    input  logic                   S_AXI_BREADY,
    input  plic_pkg::axi_addr_t    S_AXI_ARADDR,
    input  logic [2:0]             S_AXI_ARPROT,
    input  logic                   S_AXI_ARVALID,
    output logic                   S_AXI_ARREADY,
    output plic_pkg::axi_data_t    S_AXI_RDATA,
    output logic [1:0]             S_AXI_RRESP,
    output logic                   S_AXI_RVALID,
    input  logic                   S_AXI_RREADY,
    input  logic [NUM_SOURCES-1:0] irq_sources,
    output logic                   irq_valid
);

    import plic_pkg::*;

    axi_wr_state_t wr_state;
    axi_rd_state_t rd_state;
    axi_addr_t     awaddr_q;
    axi_data_t     rdata_q;
    axi_data_t     core_rdata;
    reg_wr_t       wr;
    reg_rd_t       rd;
    logic          aw_hs;
    logic          w_hs;

    assign S_AXI_AWREADY = (wr_state == WR_ADDR);
    // W waits for AW so data never lands on a stale address
    assign S_AXI_WREADY  = (wr_state == WR_DATA) ||
                           ((wr_state == WR_ADDR) && S_AXI_AWVALID);
    assign S_AXI_BVALID  = (wr_state == WR_RESP);
    assign S_AXI_BRESP   = 2'b00;

    assign S_AXI_ARREADY = (rd_state == RD_ADDR);
    assign S_AXI_RVALID  = (rd_state == RD_DATA);
    assign S_AXI_RDATA   = rdata_q;
    assign S_AXI_RRESP   = 2'b00;

    assign aw_hs = S_AXI_AWVALID && S_AXI_AWREADY;
    assign w_hs  = S_AXI_WVALID && S_AXI_WREADY;

    assign wr.addr = (wr_state == WR_DATA) ? awaddr_q : S_AXI_AWADDR;
    assign wr.data = S_AXI_WDATA;
    assign wr.strb = S_AXI_WSTRB;
    assign wr.en   = w_hs;

    assign rd.addr = S_AXI_ARADDR;
    assign rd.en   = S_AXI_ARVALID && S_AXI_ARREADY;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: wr_state <= WR_ADDR;
                WR_ADDR: begin
                    if (w_hs) begin
                        wr_state <= WR_RESP;
                    end else if (aw_hs) begin
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: if (w_hs) wr_state <= WR_RESP;
                // BREADY stall holds off the next write
                WR_RESP: if (S_AXI_BREADY) wr_state <= WR_ADDR;
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_hs) begin
            awaddr_q <= S_AXI_AWADDR;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: rd_state <= RD_ADDR;
                RD_ADDR: if (rd.en) rd_state <= RD_DATA;
                RD_DATA: if (S_AXI_RREADY) rd_state <= RD_ADDR;
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // held until the R handshake
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd.en) begin
            rdata_q <= core_rdata;
        end
    end

    plic_core #(
        .NUM_SOURCES(NUM_SOURCES)
    ) core_i (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .wr           (wr),
        .rd           (rd),
        .irq_sources  (irq_sources),
        .rdata        (core_rdata),
        .irq_valid    (irq_valid)
    );

endmodule

/* verilog/plic_core.sv */
`timescale 1ns/1ps

module plic_core #(
    parameter int NUM_SOURCES = 8
) (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    input  plic_pkg::reg_wr_t      wr,
    input  plic_pkg::reg_rd_t      rd,
    input  logic [NUM_SOURCES-1:0] irq_sources,
    output plic_pkg::axi_data_t    rdata,
    output logic                   irq_valid
);

    import plic_pkg::*;

    prio_t       [NUM_SOURCES:1] prio_q;
    logic        [NUM_SOURCES:1] enable_q;
    prio_t                       threshold_q;
    logic        [NUM_SOURCES:1] pending;
    logic        [NUM_SOURCES:1] claim;
    logic        [NUM_SOURCES:1] complete;
    arb_result_t                 best;
    src_id_t                     claim_id;
    axi_addr_t                   wr_word;
    axi_addr_t                   rd_word;
    src_id_t                     wr_idx;
    src_id_t                     rd_idx;
    axi_data_t                   enable_word;
    axi_data_t                   pending_word;
    axi_data_t                   enable_next;

    function automatic axi_data_t apply_strb(
        axi_data_t old_word,
        axi_data_t new_word,
        axi_strb_t strb
    );
        axi_data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // priority slots for sources 1..NUM_SOURCES
    function automatic logic is_prio(axi_addr_t word);
        src_id_t idx;
        idx = word[7:2];
        return (word[15:8] == PRIO_BASE[15:8]) && (idx != '0) &&
               (idx <= src_id_t'(NUM_SOURCES));
    endfunction

    assign wr_word = {wr.addr[15:2], 2'b00};
    assign rd_word = {rd.addr[15:2], 2'b00};
    assign wr_idx  = wr_word[7:2];
    assign rd_idx  = rd_word[7:2];

    // bit n of the word is source n, bit 0 stays zero
    always_comb begin
        enable_word                  = '0;
        pending_word                 = '0;
        enable_word[NUM_SOURCES:1]   = enable_q;
        pending_word[NUM_SOURCES:1]  = pending;
    end

    assign enable_next = apply_strb(enable_word, wr.data, wr.strb);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            prio_q      <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (wr.en) begin
            if (is_prio(wr_word)) begin
                prio_q[wr_idx] <= prio_t'(apply_strb(axi_data_t'(prio_q[wr_idx]),
                                                     wr.data, wr.strb));
            end
            if (wr_word == ENABLE_OFFS) begin
                enable_q <= enable_next[NUM_SOURCES:1];
            end
            if (wr_word == THRESHOLD_OFFS) begin
                threshold_q <= prio_t'(apply_strb(axi_data_t'(threshold_q),
                                                  wr.data, wr.strb));
            end
        end
    end

    assign claim_id = (best.prio > threshold_q) ? best.id : '0;

    always_comb begin
        rdata = '0;
        if (is_prio(rd_word)) begin
            rdata = axi_data_t'(prio_q[rd_idx]);
        end else begin
            case (rd_word)
                PENDING_OFFS:   rdata = pending_word;
                ENABLE_OFFS:    rdata = enable_word;
                THRESHOLD_OFFS: rdata = axi_data_t'(threshold_q);
                CLAIM_OFFS:     rdata = axi_data_t'(claim_id);
                default:        rdata = '0;
            endcase
        end
    end

    for (genvar g = 1; g <= NUM_SOURCES; g++) begin : gen_src
        assign claim[g]    = rd.en && (rd_word == CLAIM_OFFS) &&
                             (claim_id == src_id_t'(g));
        assign complete[g] = wr.en && (wr_word == CLAIM_OFFS) &&
                             (wr.data == axi_data_t'(g));

        plic_gateway gateway_i (
            .S_AXI_ACLK   (S_AXI_ACLK),
            .S_AXI_ARESETN(S_AXI_ARESETN),
            .src          (irq_sources[g-1]),
            .claim        (claim[g]),
            .complete     (complete[g]),
            .pending      (pending[g])
        );
    end

    plic_arbiter #(
        .NUM_SOURCES(NUM_SOURCES)
    ) arbiter_i (
        .pending(pending),
        .enable (enable_q),
        .prio   (prio_q),
        .best   (best)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            irq_valid <= 1'b0;
        end else begin
            irq_valid <= best.prio > threshold_q;
        end
    end

endmodule

/* verilog/plic_arbiter.sv */
`timescale 1ns/1ps

module plic_arbiter #(
    parameter int NUM_SOURCES = 8
) (
    input  logic                  [NUM_SOURCES:1] pending,
    input  logic                  [NUM_SOURCES:1] enable,
    input  plic_pkg::prio_t       [NUM_SOURCES:1] prio,
    output plic_pkg::arb_result_t                 best
);

    import plic_pkg::*;

    logic [NUM_SOURCES:1] eligible;

    assign eligible = pending & enable;

    // ascending scan with a strict compare keeps the lowest id on ties
    always_comb begin
        best = '0;
        for (int i = 1; i <= NUM_SOURCES; i++) begin
            // best.prio starts at 0, so priority 0 never wins
            if (eligible[i] && (prio[i] > best.prio)) begin
                best.id   = src_id_t'(i);
                best.prio = prio[i];
            end
        end
    end

endmodule

/* verilog/plic_gateway.sv */
`timescale 1ns/1ps

module plic_gateway (
    input  logic S_AXI_ACLK,
    input  logic S_AXI_ARESETN,
    input  logic src,
    input  logic claim,
    input  logic complete,
    output logic pending
);

    logic in_service;

    // level gateway: one outstanding request per source
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            pending    <= 1'b0;
            in_service <= 1'b0;
        end else begin
            if (claim) begin
                pending    <= 1'b0;
                in_service <= 1'b1;
            end else begin
                if (complete) begin
                    in_service <= 1'b0;
                end
                // sticky until claimed
                if (src && !in_service) begin
                    pending <= 1'b1;
                end
            end
        end
    end

    // a still-high level re-arms pending on the edge after
    // in_service drops, since the set term sees the new state
    // only then

endmodule

/* verilog/plic_pkg.sv */
package plic_pkg;

    // bus and register widths
    typedef logic [15:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;

    // id 0 is reserved for "no source"
    typedef logic [5:0]  src_id_t;
    typedef logic [2:0]  prio_t;

    // register map, byte offsets
    localparam axi_addr_t PRIO_BASE      = 16'h0000;
    localparam axi_addr_t PENDING_OFFS   = 16'h1000;
    localparam axi_addr_t ENABLE_OFFS    = 16'h2000;
    localparam axi_addr_t THRESHOLD_OFFS = 16'h3000;
    localparam axi_addr_t CLAIM_OFFS     = 16'h3004;

    // single-cycle write strobe into the core
    typedef struct packed {
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
        logic      en;
    } reg_wr_t;

    typedef struct packed {
        axi_addr_t addr;
        logic      en;
    } reg_rd_t;

    typedef struct packed {
        src_id_t id;
        prio_t   prio;
    } arb_result_t;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} axi_wr_state_t;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} axi_rd_state_t;

endpackage
